/* hdl/fpu_defs.svh */
// FP execution slot sizing
// Sizes shared by the ROB types and the FP datapath

`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// ==============================
// ROB
// ==============================

// Entries in the reorder buffer, one stomp bit per entry
`define FPU_ROB_ENTRIES 16

// ==============================
// Datapath
// ==============================

// One register word holds a double or two packed singles
`define FPU_WORD_W 64
`define FPU_WORD_BYTES 8
// Architectural destination register number
`define FPU_AREG_W 6

`endif

/* hdl/rob_pkg.sv */
// ROB bookkeeping types
// Index and stomp mask used to squash in-flight operations

`include "fpu_defs.svh"

package rob_pkg;

	// Entry number inside the reorder buffer
	typedef logic [$clog2(`FPU_ROB_ENTRIES)-1:0] rob_idx_t;

	// One bit per ROB entry
	// A set bit squashes every operation that carries that index
	typedef logic [`FPU_ROB_ENTRIES-1:0] rob_mask_t;

endpackage

/* hdl/fpu_pkg.sv */
// FP operation types
// Opcodes, formats, cause codes and the two views of an FP register word

package fpu_pkg;

	// ==============================
	// Operation encoding
	// ==============================

	// Sign manipulation, min/max and compares
	typedef enum logic [2:0] {
		OP_NOP  = 3'd0,
		OP_NEG  = 3'd1,
		OP_ABS  = 3'd2,
		OP_SGNJ = 3'd3,
		OP_MIN  = 3'd4,
		OP_MAX  = 3'd5,
		OP_EQ   = 3'd6,
		OP_LT   = 3'd7
	} fp_op_t;

	// FMT_S2 keeps lane 0 in the low 32 bits
	typedef enum logic {
		FMT_D  = 1'b0,
		FMT_S2 = 1'b1
	} fp_fmt_t;

	typedef enum logic [1:0] {
		CAUSE_NONE    = 2'd0,
		CAUSE_INVALID = 2'd1
	} fp_cause_t;

	// ==============================
	// Register word views
	// ==============================

	typedef struct packed {
		logic        sign;
		logic [10:0] exp;
		logic [51:0] man;
	} fp_dbl_t;

	typedef struct packed {
		logic        sign;
		logic [7:0]  exp;
		logic [22:0] man;
	} fp_sgl_t;

	// Same 64 bits seen as one double or as two singles
	typedef union packed {
		fp_dbl_t       d;
		fp_sgl_t [1:0] s;
	} fp_word_u;

endpackage

/* hdl/fp_lane_alu.sv */
// IEEE lane of configurable width
// Sign injection, min/max and compares with invalid detection

`timescale 1ns/1ps

module fp_lane_alu
	import fpu_pkg::*;
#(
	parameter int EXP_W = 11,
	parameter int MAN_W = 52
) (
	input  fp_op_t                 op_i,
	input  logic [EXP_W+MAN_W:0]   a_i,
	input  logic [EXP_W+MAN_W:0]   b_i,
	output logic [EXP_W+MAN_W:0]   res_o,
	output logic                   invalid_o
);

	localparam int W = EXP_W + MAN_W + 1;

	logic           a_sign;
	logic           b_sign;
	logic [W-2:0]   a_mag;
	logic [W-2:0]   b_mag;
	logic           a_nan;
	logic           b_nan;
	logic           a_snan;
	logic           b_snan;
	logic           any_nan;
	logic           both_zero;
	logic           a_below;
	logic [W-1:0]   qnan;

	// ==============================
	// Classification
	// ==============================

	assign a_sign = a_i[W-1];
	assign b_sign = b_i[W-1];
	assign a_mag  = a_i[W-2:0];
	assign b_mag  = b_i[W-2:0];

	// All-ones exponent with a nonzero mantissa is a NaN
	// The top mantissa bit clear marks it as signaling
	assign a_nan  = (&a_i[W-2:MAN_W]) && (|a_i[MAN_W-1:0]);
	assign b_nan  = (&b_i[W-2:MAN_W]) && (|b_i[MAN_W-1:0]);
	assign a_snan = a_nan && !a_i[MAN_W-1];
	assign b_snan = b_nan && !b_i[MAN_W-1];
	assign any_nan = a_nan || b_nan;

	// +0 and -0 compare equal for EQ and LT
	assign both_zero = (a_mag == '0) && (b_mag == '0);

	// Canonical quiet NaN, positive with only the quiet bit set
	assign qnan = {1'b0, {EXP_W{1'b1}}, 1'b1, {(MAN_W-1){1'b0}}};

	// Total order on sign and magnitude, so -0 sits below +0
	always_comb begin
		if (a_sign != b_sign)
			a_below = a_sign;
		else if (a_sign)
			a_below = a_mag > b_mag;
		else
			a_below = a_mag < b_mag;
	end

	// ==============================
	// Lane rules
	// ==============================

	always_comb begin
		res_o = a_i;
		invalid_o = 1'b0;
		case (op_i)
			OP_NEG:  res_o = {~a_sign, a_mag};
			OP_ABS:  res_o = {1'b0, a_mag};
			OP_SGNJ: res_o = {b_sign, a_mag};
			OP_MIN, OP_MAX: begin
				invalid_o = a_snan || b_snan;
				// A single NaN yields the other operand
				if (a_nan && b_nan)
					res_o = qnan;
				else if (a_nan)
					res_o = b_i;
				else if (b_nan)
					res_o = a_i;
				else if (a_below == (op_i == OP_MIN))
					res_o = a_i;
				else
					res_o = b_i;
			end
			OP_EQ: begin
				invalid_o = a_snan || b_snan;
				res_o = {{(W-1){1'b0}}, !any_nan && ((a_i == b_i) || both_zero)};
			end
			OP_LT: begin
				// Ordered compare, so a quiet NaN is invalid as well
				invalid_o = any_nan;
				res_o = {{(W-1){1'b0}}, !any_nan && !both_zero && a_below};
			end
			default: res_o = a_i;
		endcase
	end

	// Sign operations are pure bit moves and never signal
	always_comb begin
		if (op_i inside {OP_NEG, OP_ABS, OP_SGNJ})
			assert (!invalid_o) else $error("invalid raised by a sign operation");
	end

endmodule

/* hdl/meta_fpu.sv */
// Meta FP unit
// Two-stage conveyor around one double lane and two single lanes, with
// sticky stomp kills, copy-target merge and write-enable generation

`timescale 1ns/1ps
`include "fpu_defs.svh"

module meta_fpu
	import rob_pkg::*;
	import fpu_pkg::*;
(
	input  logic                        clk,
	input  logic                        arst_n_i,
	input  logic                        issue_i,
	input  fp_op_t                      op_i,
	input  fp_fmt_t                     fmt_i,
	input  rob_idx_t                    rob_i,
	input  logic [`FPU_AREG_W-1:0]      rd_i,
	input  logic [`FPU_WORD_W-1:0]      a_i,
	input  logic [`FPU_WORD_W-1:0]      b_i,
	input  logic [`FPU_WORD_W-1:0]      t_i,
	input  logic [`FPU_WORD_BYTES-1:0]  cptgt_i,
	input  logic                        z_i,
	input  rob_mask_t                   stomp_i,
	input  logic                        wb_rdy_i,
	output logic                        rdy_o,
	output logic                        out_vld_o,
	output rob_idx_t                    rob_o,
	output logic [`FPU_AREG_W-1:0]      rd_o,
	output logic [`FPU_WORD_W-1:0]      data_o,
	output logic [`FPU_WORD_BYTES-1:0]  we_o,
	output fp_cause_t                   exc_o
);

	// Stage 1 holds the issued operation
	logic                        s1_vld;
	logic                        s1_kill;
	fp_op_t                      s1_op;
	fp_fmt_t                     s1_fmt;
	rob_idx_t                    s1_rob;
	logic [`FPU_AREG_W-1:0]      s1_rd;
	fp_word_u                    s1_a;
	fp_word_u                    s1_b;
	logic [`FPU_WORD_W-1:0]      s1_t;
	logic [`FPU_WORD_BYTES-1:0]  s1_cptgt;
	logic                        s1_z;
	// Stage 2 holds the merged result and the target for a late kill
	logic                        s2_vld;
	logic                        s2_kill;
	logic                        s2_dead;
	rob_idx_t                    s2_rob;
	logic [`FPU_AREG_W-1:0]      s2_rd;
	logic [`FPU_WORD_W-1:0]      s2_data;
	logic [`FPU_WORD_W-1:0]      s2_t;
	fp_cause_t                   s2_exc;
	// Lane outputs and selection
	logic [`FPU_WORD_W-1:0]      res_d;
	logic                        inv_d;
	logic [1:0][31:0]            res_s;
	logic [1:0]                  inv_s;
	logic [`FPU_WORD_W-1:0]      lane_res;
	fp_cause_t                   lane_exc;
	logic [`FPU_WORD_W-1:0]      merged;
	logic                        s2_free;
	logic                        s1_adv;

	// ==============================
	// Precision lanes
	// ==============================

	fp_lane_alu #(.EXP_W(11), .MAN_W(52)) lane_d_i (
		.op_i      (s1_op),
		.a_i       (s1_a.d),
		.b_i       (s1_b.d),
		.res_o     (res_d),
		.invalid_o (inv_d)
	);

	for (genvar g = 0; g < 2; g++) begin : g_single
		fp_lane_alu #(.EXP_W(8), .MAN_W(23)) lane_s_i (
			.op_i      (s1_op),
			.a_i       (s1_a.s[g]),
			.b_i       (s1_b.s[g]),
			.res_o     (res_s[g]),
			.invalid_o (inv_s[g])
		);
	end

	// NOP passes the old target through, otherwise the format picks the lanes
	always_comb begin
		if (s1_op == OP_NOP) begin
			lane_res = s1_t;
			lane_exc = CAUSE_NONE;
		end else if (s1_fmt == FMT_D) begin
			lane_res = res_d;
			lane_exc = inv_d ? CAUSE_INVALID : CAUSE_NONE;
		end else begin
			lane_res = res_s;
			lane_exc = (|inv_s) ? CAUSE_INVALID : CAUSE_NONE;
		end
		// Masked bytes keep the target or are zeroed
		for (int m = 0; m < `FPU_WORD_BYTES; m++) begin
			if (s1_cptgt[m])
				merged[m*8 +: 8] = s1_z ? 8'h00 : s1_t[m*8 +: 8];
			else
				merged[m*8 +: 8] = lane_res[m*8 +: 8];
		end
	end

	// ==============================
	// Conveyor
	// ==============================

	// Stage 2 drains into the writeback port, stage 1 moves when it can
	assign s2_free = !s2_vld || wb_rdy_i;
	assign s1_adv  = s1_vld && s2_free;
	assign rdy_o   = !s1_vld || s2_free;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			s1_vld  <= 1'b0;
			s1_kill <= 1'b0;
			s2_vld  <= 1'b0;
			s2_kill <= 1'b0;
		end else begin
			// A zero destination register makes the operation a no-write
			if (issue_i) begin
				s1_vld  <= 1'b1;
				s1_kill <= stomp_i[rob_i] || (rd_i == '0);
			end else if (s1_adv) begin
				s1_vld  <= 1'b0;
				s1_kill <= 1'b0;
			end else begin
				s1_kill <= s1_kill || (s1_vld && stomp_i[s1_rob]);
			end
			// Kill bits stay sticky while a stage waits
			if (s1_adv) begin
				s2_vld  <= 1'b1;
				s2_kill <= s1_kill || stomp_i[s1_rob];
			end else if (s2_vld && wb_rdy_i) begin
				s2_vld  <= 1'b0;
				s2_kill <= 1'b0;
			end else begin
				s2_kill <= s2_kill || (s2_vld && stomp_i[s2_rob]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue_i) begin
			s1_op    <= op_i;
			s1_fmt   <= fmt_i;
			s1_rob   <= rob_i;
			s1_rd    <= rd_i;
			s1_a     <= a_i;
			s1_b     <= b_i;
			s1_t     <= t_i;
			s1_cptgt <= cptgt_i;
			s1_z     <= z_i;
		end
		if (s1_adv) begin
			s2_rob  <= s1_rob;
			s2_rd   <= s1_rd;
			s2_data <= merged;
			s2_t    <= s1_t;
			s2_exc  <= lane_exc;
		end
	end

	// A stomp in the cycle that stage 2 drains still reaches the result
	assign s2_dead = s2_kill || stomp_i[s2_rob];

	// A killed operation returns its target with no byte enables
	assign out_vld_o = s2_vld;
	assign rob_o     = s2_rob;
	assign rd_o      = s2_rd;
	assign data_o    = s2_dead ? s2_t : s2_data;
	assign we_o      = s2_dead ? '0 : '1;
	assign exc_o     = s2_dead ? CAUSE_NONE : s2_exc;

	// The issue port only fires after it has seen this unit ready
	assert property (@(posedge clk) disable iff (!arst_n_i) issue_i |-> rdy_o)
		else $error("issue while meta_fpu not ready");

endmodule

/* hdl/fpu_issue_port.sv */
// Issue port
// Four-phase req/ack receiver that turns an accepted request into one issue cycle

`timescale 1ns/1ps
`include "fpu_defs.svh"

module fpu_issue_port
	import rob_pkg::*;
	import fpu_pkg::*;
(
	input  logic                        clk,
	input  logic                        arst_n_i,
	input  logic                        req_i,
	input  logic                        rdy_i,
	input  fp_op_t                      op_i,
	input  fp_fmt_t                     fmt_i,
	input  rob_idx_t                    rob_i,
	input  logic [`FPU_AREG_W-1:0]      rd_i,
	input  logic [`FPU_WORD_W-1:0]      a_i,
	input  logic [`FPU_WORD_W-1:0]      b_i,
	input  logic [`FPU_WORD_W-1:0]      t_i,
	input  logic [`FPU_WORD_BYTES-1:0]  cptgt_i,
	input  logic                        z_i,
	output logic                        ack_o,
	output logic                        issue_o,
	output fp_op_t                      op_o,
	output fp_fmt_t                     fmt_o,
	output rob_idx_t                    rob_o,
	output logic [`FPU_AREG_W-1:0]      rd_o,
	output logic [`FPU_WORD_W-1:0]      a_o,
	output logic [`FPU_WORD_W-1:0]      b_o,
	output logic [`FPU_WORD_W-1:0]      t_o,
	output logic [`FPU_WORD_BYTES-1:0]  cptgt_o,
	output logic                        z_o
);

	// ACKED is the single issue cycle, WAIT_LO keeps ack up until req falls
	typedef enum logic [1:0] {ST_IDLE, ST_ACKED, ST_WAIT_LO} state_t;

	state_t state;
	logic   accept;

	assign accept = (state == ST_IDLE) && req_i && rdy_i;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			state <= ST_IDLE;
		else begin
			case (state)
				ST_IDLE:    if (accept) state <= ST_ACKED;
				ST_ACKED:   state <= ST_WAIT_LO;
				ST_WAIT_LO: if (!req_i) state <= ST_IDLE;
				default:    state <= ST_IDLE;
			endcase
		end
	end

	// Fields are stable while req is up, so take them on acceptance
	always_ff @(posedge clk) begin
		if (accept) begin
			op_o    <= op_i;
			fmt_o   <= fmt_i;
			rob_o   <= rob_i;
			rd_o    <= rd_i;
			a_o     <= a_i;
			b_o     <= b_i;
			t_o     <= t_i;
			cptgt_o <= cptgt_i;
			z_o     <= z_i;
		end
	end

	assign ack_o   = (state != ST_IDLE);
	assign issue_o = (state == ST_ACKED);

	// Ack may only answer a request that is still being held
	assert property (@(posedge clk) disable iff (!arst_n_i) $rose(ack_o) |-> req_i)
		else $error("ack rose without a request");

endmodule

/* hdl/fpu_wb_port.sv */
// Writeback port
// Four-phase sender that holds one result until the receiver acknowledges it

`timescale 1ns/1ps
`include "fpu_defs.svh"

module fpu_wb_port
	import rob_pkg::*;
	import fpu_pkg::*;
(
	input  logic                        clk,
	input  logic                        arst_n_i,
	input  logic                        vld_i,
	input  rob_idx_t                    rob_i,
	input  logic [`FPU_AREG_W-1:0]      rd_i,
	input  logic [`FPU_WORD_W-1:0]      data_i,
	input  logic [`FPU_WORD_BYTES-1:0]  we_i,
	input  fp_cause_t                   exc_i,
	input  logic                        wb_ack_i,
	output logic                        rdy_o,
	output logic                        wb_req_o,
	output rob_idx_t                    wb_rob_o,
	output logic [`FPU_AREG_W-1:0]      wb_rd_o,
	output logic [`FPU_WORD_W-1:0]      wb_data_o,
	output logic [`FPU_WORD_BYTES-1:0]  wb_we_o,
	output fp_cause_t                   wb_exc_o
);

	typedef enum logic [1:0] {ST_EMPTY, ST_REQ, ST_WAIT_LO} state_t;

	state_t state;
	logic   load;

	// Only an empty port takes a new result
	assign rdy_o = (state == ST_EMPTY);
	assign load  = rdy_o && vld_i;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			state <= ST_EMPTY;
		else begin
			case (state)
				ST_EMPTY:   if (load) state <= ST_REQ;
				ST_REQ:     if (wb_ack_i) state <= ST_WAIT_LO;
				ST_WAIT_LO: if (!wb_ack_i) state <= ST_EMPTY;
				default:    state <= ST_EMPTY;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			wb_rob_o  <= rob_i;
			wb_rd_o   <= rd_i;
			wb_data_o <= data_i;
			wb_we_o   <= we_i;
			wb_exc_o  <= exc_i;
		end
	end

	assign wb_req_o = (state == ST_REQ);

	// The request is never withdrawn before the receiver answers
	assert property (@(posedge clk) disable iff (!arst_n_i)
		wb_req_o && !wb_ack_i |=> wb_req_o)
		else $error("wb_req_o dropped without ack");

endmodule

/* hdl/fp_exec_top.sv */
// FP execution slot
// Issue port, meta FP unit and writeback port in a chain

`timescale 1ns/1ps
`include "fpu_defs.svh"

module fp_exec_top
	import rob_pkg::*;
	import fpu_pkg::*;
(
	input  logic                        clk,
	input  logic                        arst_n_i,
	input  logic                        req_i,
	output logic                        ack_o,
	input  fp_op_t                      op_i,
	input  fp_fmt_t                     fmt_i,
	input  rob_idx_t                    rob_i,
	input  logic [`FPU_AREG_W-1:0]      rd_i,
	input  logic [`FPU_WORD_W-1:0]      a_i,
	input  logic [`FPU_WORD_W-1:0]      b_i,
	input  logic [`FPU_WORD_W-1:0]      t_i,
	input  logic [`FPU_WORD_BYTES-1:0]  cptgt_i,
	input  logic                        z_i,
	input  rob_mask_t                   stomp_i,
	output logic                        wb_req_o,
	input  logic                        wb_ack_i,
	output rob_idx_t                    wb_rob_o,
	output logic [`FPU_AREG_W-1:0]      wb_rd_o,
	output logic [`FPU_WORD_W-1:0]      wb_data_o,
	output logic [`FPU_WORD_BYTES-1:0]  wb_we_o,
	output fp_cause_t                   wb_exc_o
);

	// Issue port to meta unit
	logic                        issue;
	logic                        meta_rdy;
	fp_op_t                      iss_op;
	fp_fmt_t                     iss_fmt;
	rob_idx_t                    iss_rob;
	logic [`FPU_AREG_W-1:0]      iss_rd;
	logic [`FPU_WORD_W-1:0]      iss_a;
	logic [`FPU_WORD_W-1:0]      iss_b;
	logic [`FPU_WORD_W-1:0]      iss_t;
	logic [`FPU_WORD_BYTES-1:0]  iss_cptgt;
	logic                        iss_z;
	// Meta unit to writeback port
	logic                        res_vld;
	logic                        wb_rdy;
	rob_idx_t                    res_rob;
	logic [`FPU_AREG_W-1:0]      res_rd;
	logic [`FPU_WORD_W-1:0]      res_data;
	logic [`FPU_WORD_BYTES-1:0]  res_we;
	fp_cause_t                   res_exc;

	fpu_issue_port issue_port_i (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.req_i    (req_i),
		.rdy_i    (meta_rdy),
		.op_i     (op_i),
		.fmt_i    (fmt_i),
		.rob_i    (rob_i),
		.rd_i     (rd_i),
		.a_i      (a_i),
		.b_i      (b_i),
		.t_i      (t_i),
		.cptgt_i  (cptgt_i),
		.z_i      (z_i),
		.ack_o    (ack_o),
		.issue_o  (issue),
		.op_o     (iss_op),
		.fmt_o    (iss_fmt),
		.rob_o    (iss_rob),
		.rd_o     (iss_rd),
		.a_o      (iss_a),
		.b_o      (iss_b),
		.t_o      (iss_t),
		.cptgt_o  (iss_cptgt),
		.z_o      (iss_z)
	);

	// Stomps reach only the operations still inside the meta unit
	meta_fpu meta_fpu_i (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.issue_i   (issue),
		.op_i      (iss_op),
		.fmt_i     (iss_fmt),
		.rob_i     (iss_rob),
		.rd_i      (iss_rd),
		.a_i       (iss_a),
		.b_i       (iss_b),
		.t_i       (iss_t),
		.cptgt_i   (iss_cptgt),
		.z_i       (iss_z),
		.stomp_i   (stomp_i),
		.wb_rdy_i  (wb_rdy),
		.rdy_o     (meta_rdy),
		.out_vld_o (res_vld),
		.rob_o     (res_rob),
		.rd_o      (res_rd),
		.data_o    (res_data),
		.we_o      (res_we),
		.exc_o     (res_exc)
	);

	fpu_wb_port wb_port_i (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.vld_i     (res_vld),
		.rob_i     (res_rob),
		.rd_i      (res_rd),
		.data_i    (res_data),
		.we_i      (res_we),
		.exc_i     (res_exc),
		.wb_ack_i  (wb_ack_i),
		.rdy_o     (wb_rdy),
		.wb_req_o  (wb_req_o),
		.wb_rob_o  (wb_rob_o),
		.wb_rd_o   (wb_rd_o),
		.wb_data_o (wb_data_o),
		.wb_we_o   (wb_we_o),
		.wb_exc_o  (wb_exc_o)
	);

endmodule

/* sim/tb_fp_exec.sv */
// Testbench for the FP execution slot
// Directed tests over the issue and writeback handshakes, checked against
// a reference model of the lane rules

`timescale 1ns/1ps
`include "fpu_defs.svh"

module tb_fp_exec
	import rob_pkg::*;
	import fpu_pkg::*;
;

	// ==============================
	// Constants
	// ==============================

	localparam int D_ITERS     = 4;
	localparam int S_ITERS     = 2;
	// Random and edge double ops, lane ops, cause, copy mask and stomp tests
	localparam int NUM_OPS     = D_ITERS*5 + 6 + 3 + S_ITERS*5 + 4 + 4 + 2;
	localparam int CYCLE_LIMIT = NUM_OPS*40 + 8;

	localparam logic [63:0] D_PZERO = 64'h0000_0000_0000_0000;
	localparam logic [63:0] D_NZERO = 64'h8000_0000_0000_0000;
	localparam logic [63:0] D_ONE   = 64'h3FF0_0000_0000_0000;
	localparam logic [63:0] D_TWO   = 64'h4000_0000_0000_0000;
	localparam logic [63:0] D_NINF  = 64'hFFF0_0000_0000_0000;
	localparam logic [63:0] D_QNAN  = 64'h7FF8_0000_0000_0000;
	localparam logic [63:0] D_SNAN  = 64'h7FF0_0000_0000_0001;
	localparam logic [31:0] S_PZERO = 32'h0000_0000;
	localparam logic [31:0] S_NZERO = 32'h8000_0000;
	localparam logic [31:0] S_ONE   = 32'h3F80_0000;
	localparam logic [31:0] S_MTWO  = 32'hC000_0000;
	localparam logic [31:0] S_QNAN  = 32'h7FC0_0000;
	localparam logic [31:0] S_SNAN  = 32'h7F80_0001;

	// One operation as the reservation station presents it
	typedef struct packed {
		fp_op_t                      op;
		fp_fmt_t                     fmt;
		rob_idx_t                    rob;
		logic [`FPU_AREG_W-1:0]      rd;
		logic [`FPU_WORD_W-1:0]      a;
		logic [`FPU_WORD_W-1:0]      b;
		logic [`FPU_WORD_W-1:0]      t;
		logic [`FPU_WORD_BYTES-1:0]  cptgt;
		logic                        z;
	} op_rec_t;

	logic                        clk;
	logic                        arst_n_i;
	logic                        req_i;
	logic                        ack_o;
	fp_op_t                      op_i;
	fp_fmt_t                     fmt_i;
	rob_idx_t                    rob_i;
	logic [`FPU_AREG_W-1:0]      rd_i;
	logic [`FPU_WORD_W-1:0]      a_i;
	logic [`FPU_WORD_W-1:0]      b_i;
	logic [`FPU_WORD_W-1:0]      t_i;
	logic [`FPU_WORD_BYTES-1:0]  cptgt_i;
	logic                        z_i;
	rob_mask_t                   stomp_i;
	logic                        wb_req_o;
	logic                        wb_ack_i;
	rob_idx_t                    wb_rob_o;
	logic [`FPU_AREG_W-1:0]      wb_rd_o;
	logic [`FPU_WORD_W-1:0]      wb_data_o;
	logic [`FPU_WORD_BYTES-1:0]  wb_we_o;
	fp_cause_t                   wb_exc_o;

	int       cycles = 0;
	rob_idx_t next_rob = '0;

	fp_exec_top fp_exec_top_i (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.req_i     (req_i),
		.ack_o     (ack_o),
		.op_i      (op_i),
		.fmt_i     (fmt_i),
		.rob_i     (rob_i),
		.rd_i      (rd_i),
		.a_i       (a_i),
		.b_i       (b_i),
		.t_i       (t_i),
		.cptgt_i   (cptgt_i),
		.z_i       (z_i),
		.stomp_i   (stomp_i),
		.wb_req_o  (wb_req_o),
		.wb_ack_i  (wb_ack_i),
		.wb_rob_o  (wb_rob_o),
		.wb_rd_o   (wb_rd_o),
		.wb_data_o (wb_data_o),
		.wb_we_o   (wb_we_o),
		.wb_exc_o  (wb_exc_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Watchdog sized from the number of operations in the run
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the DUT did not finish within %0d cycles", CYCLE_LIMIT);
			$display("** FAIL **");
			$fatal(1, "run stopped by the watchdog");
		end
	end

	// ==============================
	// Reference model
	// ==============================

	// One IEEE lane of w bits with mw mantissa bits, operands zero-extended
	function automatic logic [63:0] lane_value(input fp_op_t op, input logic [63:0] a,
			input logic [63:0] b, input int w, input int mw, output logic inv);
		logic [63:0] sgn;
		logic [63:0] mag;
		logic [63:0] man;
		logic [63:0] ex;
		logic [63:0] qbit;
		logic        a_nan;
		logic        b_nan;
		logic        a_snan;
		logic        b_snan;
		logic        zeros;
		logic        a_first;
		logic [63:0] res;
		sgn    = 64'h1 << (w - 1);
		mag    = sgn - 64'h1;
		man    = (64'h1 << mw) - 64'h1;
		ex     = mag & ~man;
		qbit   = 64'h1 << (mw - 1);
		a_nan  = ((a & ex) == ex) && ((a & man) != 0);
		b_nan  = ((b & ex) == ex) && ((b & man) != 0);
		a_snan = a_nan && ((a & qbit) == 0);
		b_snan = b_nan && ((b & qbit) == 0);
		zeros  = ((a & mag) == 0) && ((b & mag) == 0);
		// Sign first, then magnitude, which puts -0 ahead of +0
		if ((a & sgn) != (b & sgn))
			a_first = (a & sgn) != 0;
		else if ((a & sgn) != 0)
			a_first = (a & mag) > (b & mag);
		else
			a_first = (a & mag) < (b & mag);
		inv = 1'b0;
		res = a;
		case (op)
			OP_NEG:  res = a ^ sgn;
			OP_ABS:  res = a & mag;
			OP_SGNJ: res = (a & mag) | (b & sgn);
			OP_MIN, OP_MAX: begin
				inv = a_snan || b_snan;
				if (a_nan && b_nan)
					res = ex | qbit;
				else if (a_nan)
					res = b;
				else if (b_nan)
					res = a;
				else if (op == OP_MIN)
					res = a_first ? a : b;
				else
					res = a_first ? b : a;
			end
			OP_EQ: begin
				inv = a_snan || b_snan;
				res = (!a_nan && !b_nan && (a == b || zeros)) ? 64'h1 : 64'h0;
			end
			OP_LT: begin
				inv = a_nan || b_nan;
				res = (!a_nan && !b_nan && !zeros && a_first) ? 64'h1 : 64'h0;
			end
			default: res = a;
		endcase
		return res;
	endfunction

	// Whole expected word with format split, copy mask and rd zero kill
	function automatic logic [63:0] ref_word(input op_rec_t r, output logic inv);
		logic [63:0] res;
		logic [63:0] lo;
		logic [63:0] hi;
		logic        inv_lo;
		logic        inv_hi;
		inv = 1'b0;
		if (r.op == OP_NOP) begin
			res = r.t;
		end else if (r.fmt == FMT_D) begin
			res = lane_value(r.op, r.a, r.b, 64, 52, inv);
		end else begin
			lo  = lane_value(r.op, {32'h0, r.a[31:0]}, {32'h0, r.b[31:0]}, 32, 23, inv_lo);
			hi  = lane_value(r.op, {32'h0, r.a[63:32]}, {32'h0, r.b[63:32]}, 32, 23, inv_hi);
			res = {hi[31:0], lo[31:0]};
			inv = inv_lo || inv_hi;
		end
		for (int i = 0; i < `FPU_WORD_BYTES; i++) begin
			if (r.cptgt[i])
				res[i*8 +: 8] = r.z ? 8'h00 : r.t[i*8 +: 8];
		end
		if (r.rd == '0) begin
			res = r.t;
			inv = 1'b0;
		end
		return res;
	endfunction

	// ==============================
	// Stimulus and checks
	// ==============================

	function automatic op_rec_t new_op(input fp_op_t op, input fp_fmt_t fmt,
			input logic [63:0] a, input logic [63:0] b);
		op_rec_t r;
		r.op     = op;
		r.fmt    = fmt;
		r.rob    = next_rob;
		next_rob = next_rob + 1'b1;
		r.rd     = `FPU_AREG_W'($urandom_range(63, 1));
		r.a      = a;
		r.b      = b;
		r.t      = {$urandom, $urandom};
		r.cptgt  = '0;
		r.z      = 1'b0;
		return r;
	endfunction

	function automatic logic [63:0] rand64();
		return {$urandom, $urandom};
	endfunction

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERR time=%0t %s got=%h exp=%h", $time, name, got, exp);
			$display("** FAIL **");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic issue_op(input op_rec_t r);
		@(posedge clk);
		op_i    <= r.op;
		fmt_i   <= r.fmt;
		rob_i   <= r.rob;
		rd_i    <= r.rd;
		a_i     <= r.a;
		b_i     <= r.b;
		t_i     <= r.t;
		cptgt_i <= r.cptgt;
		z_i     <= r.z;
		req_i   <= 1'b1;
		do @(posedge clk); while (!ack_o);
		req_i <= 1'b0;
		do @(posedge clk); while (ack_o);
	endtask

	// Fields are taken when wb_req_o is seen, then ack follows after delay cycles
	task automatic collect_wb(input int delay, output rob_idx_t rob,
			output logic [`FPU_AREG_W-1:0] rd, output logic [63:0] data,
			output logic [7:0] we, output fp_cause_t exc);
		do @(posedge clk); while (!wb_req_o);
		rob  = wb_rob_o;
		rd   = wb_rd_o;
		data = wb_data_o;
		we   = wb_we_o;
		exc  = wb_exc_o;
		repeat (delay) @(posedge clk);
		wb_ack_i <= 1'b1;
		do @(posedge clk); while (wb_req_o);
		wb_ack_i <= 1'b0;
	endtask

	task automatic check_result(input op_rec_t r, input rob_idx_t rob,
			input logic [`FPU_AREG_W-1:0] rd, input logic [63:0] data,
			input logic [7:0] we, input fp_cause_t exc);
		logic        inv;
		logic [63:0] exp_data;
		exp_data = ref_word(r, inv);
		check_eq("wb_rob_o", rob, r.rob);
		check_eq("wb_rd_o", rd, r.rd);
		check_eq("wb_data_o", data, exp_data);
		check_eq("wb_we_o", we, (r.rd == '0) ? 8'h00 : 8'hFF);
		check_eq("wb_exc_o", exc, inv ? CAUSE_INVALID : CAUSE_NONE);
	endtask

	task automatic run_op(input op_rec_t r, output logic [63:0] data,
			output logic [7:0] we, output fp_cause_t exc);
		rob_idx_t               rob;
		logic [`FPU_AREG_W-1:0] rd;
		issue_op(r);
		collect_wb(0, rob, rd, data, we, exc);
		check_result(r, rob, rd, data, we, exc);
	endtask

	// ==============================
	// Tests
	// ==============================

	task automatic test_double_ops();
		fp_op_t      ops [5];
		logic [63:0] d;
		logic [7:0]  we;
		fp_cause_t   exc;
		ops[0] = OP_NEG;
		ops[1] = OP_ABS;
		ops[2] = OP_SGNJ;
		ops[3] = OP_EQ;
		ops[4] = OP_LT;
		for (int i = 0; i < D_ITERS; i++)
			for (int k = 0; k < 5; k++)
				run_op(new_op(ops[k], FMT_D, rand64(), rand64()), d, we, exc);
		// Signed zeros compare equal
		run_op(new_op(OP_EQ, FMT_D, D_PZERO, D_NZERO), d, we, exc);
		check_eq("wb_data_o eq +0 -0", d, 64'h1);
		run_op(new_op(OP_LT, FMT_D, D_NZERO, D_PZERO), d, we, exc);
		check_eq("wb_data_o lt -0 +0", d, 64'h0);
		run_op(new_op(OP_LT, FMT_D, D_NINF, D_ONE), d, we, exc);
		run_op(new_op(OP_EQ, FMT_D, D_ONE, D_ONE), d, we, exc);
		run_op(new_op(OP_NEG, FMT_D, D_NZERO, D_ONE), d, we, exc);
		check_eq("wb_data_o neg -0", d, D_PZERO);
		run_op(new_op(OP_SGNJ, FMT_D, D_TWO, D_NINF), d, we, exc);
	endtask

	task automatic test_single_lanes();
		fp_op_t      ops [5];
		logic [63:0] d;
		logic [7:0]  we;
		fp_cause_t   exc;
		ops[0] = OP_MIN;
		ops[1] = OP_MAX;
		ops[2] = OP_EQ;
		ops[3] = OP_LT;
		ops[4] = OP_ABS;
		// High lane orders the zeros, low lane drops a single NaN
		run_op(new_op(OP_MIN, FMT_S2, {S_NZERO, S_ONE}, {S_PZERO, S_QNAN}), d, we, exc);
		check_eq("wb_data_o s2 min", d, {S_NZERO, S_ONE});
		run_op(new_op(OP_MAX, FMT_S2, {S_NZERO, S_ONE}, {S_PZERO, S_QNAN}), d, we, exc);
		check_eq("wb_data_o s2 max", d, {S_PZERO, S_ONE});
		// Two NaN payloads collapse to the canonical quiet NaN
		run_op(new_op(OP_MIN, FMT_S2, {32'h7FC0_1234, S_MTWO}, {32'hFFC0_0001, S_ONE}),
			d, we, exc);
		check_eq("wb_data_o s2 min nan", d, {S_QNAN, S_MTWO});
		for (int i = 0; i < S_ITERS; i++)
			for (int k = 0; k < 5; k++)
				run_op(new_op(ops[k], FMT_S2, rand64(), rand64()), d, we, exc);
	endtask

	task automatic test_invalid();
		logic [63:0] d;
		logic [7:0]  we;
		fp_cause_t   exc;
		run_op(new_op(OP_MIN, FMT_D, D_SNAN, D_ONE), d, we, exc);
		check_eq("wb_exc_o min snan", exc, CAUSE_INVALID);
		run_op(new_op(OP_EQ, FMT_S2, {S_SNAN, S_ONE}, {S_ONE, S_ONE}), d, we, exc);
		check_eq("wb_exc_o s2 eq snan", exc, CAUSE_INVALID);
		run_op(new_op(OP_LT, FMT_D, D_QNAN, D_ONE), d, we, exc);
		check_eq("wb_exc_o lt qnan", exc, CAUSE_INVALID);
		// Quiet NaN alone does not signal an equality test
		run_op(new_op(OP_EQ, FMT_D, D_QNAN, D_QNAN), d, we, exc);
		check_eq("wb_exc_o eq qnan", exc, CAUSE_NONE);
	endtask

	task automatic test_copy_target();
		op_rec_t     r;
		logic [63:0] d;
		logic [7:0]  we;
		fp_cause_t   exc;
		r = new_op(OP_NEG, FMT_D, rand64(), rand64());
		r.cptgt = 8'hF0;
		run_op(r, d, we, exc);
		check_eq("wb_data_o copy keeps t", d[63:32], r.t[63:32]);
		r = new_op(OP_NEG, FMT_D, rand64(), rand64());
		r.cptgt = 8'hF0;
		r.z = 1'b1;
		run_op(r, d, we, exc);
		check_eq("wb_data_o copy zeroes", d[63:32], 64'h0);
		r = new_op(OP_ABS, FMT_S2, rand64(), rand64());
		r.cptgt = 8'h0F;
		r.z = 1'b1;
		run_op(r, d, we, exc);
		// Register zero is never written
		r = new_op(OP_MAX, FMT_D, rand64(), rand64());
		r.rd = '0;
		run_op(r, d, we, exc);
		check_eq("wb_data_o rd0", d, r.t);
		check_eq("wb_we_o rd0", we, 8'h00);
	endtask

	task automatic test_stomp_backpressure();
		op_rec_t                r1;
		op_rec_t                r2;
		rob_idx_t               rob;
		logic [`FPU_AREG_W-1:0] rd;
		logic [63:0]            d;
		logic [7:0]             we;
		fp_cause_t              exc;
		r1 = new_op(OP_MAX, FMT_S2, rand64(), rand64());
		r2 = new_op(OP_SGNJ, FMT_D, rand64(), rand64());
		issue_op(r1);
		issue_op(r2);
		// First op sits in the writeback port, second waits in meta_fpu
		repeat (4) @(posedge clk);
		check_eq("wb_req_o held", wb_req_o, 1'b1);
		// Both indices stomped, only the one still in meta_fpu may die
		stomp_i <= rob_mask_t'((1 << r1.rob) | (1 << r2.rob));
		@(posedge clk);
		stomp_i <= '0;
		collect_wb(3, rob, rd, d, we, exc);
		check_result(r1, rob, rd, d, we, exc);
		collect_wb(0, rob, rd, d, we, exc);
		check_eq("wb_rob_o stomped", rob, r2.rob);
		check_eq("wb_data_o stomped", d, r2.t);
		check_eq("wb_we_o stomped", we, 8'h00);
		check_eq("wb_exc_o stomped", exc, CAUSE_NONE);
	endtask

	initial begin
		arst_n_i = 1'b0;
		req_i    = 1'b0;
		op_i     = OP_NOP;
		fmt_i    = FMT_D;
		rob_i    = '0;
		rd_i     = '0;
		a_i      = '0;
		b_i      = '0;
		t_i      = '0;
		cptgt_i  = '0;
		z_i      = 1'b0;
		stomp_i  = '0;
		wb_ack_i = 1'b0;
		void'($urandom(32'h9497df96));
		repeat (8) @(posedge clk);
		arst_n_i <= 1'b1;
		@(posedge clk);
		check_eq("ack_o after reset", ack_o, 1'b0);
		check_eq("wb_req_o after reset", wb_req_o, 1'b0);
		test_double_ops();
		test_single_lanes();
		test_invalid();
		test_copy_target();
		test_stomp_backpressure();
		$display("** PASS **");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+hdl
hdl/rob_pkg.sv
hdl/fpu_pkg.sv
hdl/fp_lane_alu.sv
hdl/meta_fpu.sv
hdl/fpu_issue_port.sv
hdl/fpu_wb_port.sv
hdl/fp_exec_top.sv
sim/tb_fp_exec.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_fp_exec
FILELIST  := filelist.f
BUILD_DIR := obj_dir
FLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
